/* logic/matrix_pkg.sv */
package matrix_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Binary16 word and field layout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [15:0] float16_t;

    parameter int exp_width = 5;   // Exponent field
    parameter int man_width = 10;  // Stored fraction, hidden bit not included
    parameter int exp_bias  = 15;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Special encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    parameter float16_t float_inf_pos = 16'h7C00;
    parameter float16_t float_inf_neg = 16'hFC00;

    // Every NaN result leaves the adder in this single quiet form
    parameter float16_t float_qnan    = 16'h7E00;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Engine control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        st_idle  = 2'd0,  // Waiting for start, done high
        st_prime = 2'd1,  // Loads the base addresses
        st_run   = 2'd2   // One element per cycle
    } engine_state_t;

endpackage

/* logic/float16_add.sv */
`timescale 1ns/100ps

module float16_add (
    input  matrix_pkg::float16_t float_a,
    input  matrix_pkg::float16_t float_b,
    output matrix_pkg::float16_t sum
);
    import matrix_pkg::*;

    localparam int ew      = exp_width;
    localparam int mw      = man_width;
    localparam int ext_w   = mw + 4;           // Hidden bit, fraction, guard, round, sticky
    localparam int sh_w    = ext_w + 2 ** ew;  // Room to shift the whole operand out
    localparam int lz_w    = $clog2(ext_w + 1);
    localparam int exp_max = 2 * exp_bias + 1; // All ones exponent

    logic          sign_a, sign_b;
    logic [ew-1:0] exp_a, exp_b;
    logic [mw-1:0] man_a, man_b;
    logic          zero_a, zero_b, inf_a, inf_b, nan_a, nan_b;

    logic          a_big;
    logic          big_sign;
    logic [ew-1:0] big_exp, small_exp, diff;
    logic [mw-1:0] big_man, small_man;

    logic [ext_w-1:0] big_ext, small_ext, small_al;
    logic [sh_w-1:0]  wide;
    logic             subtract;
    logic [ext_w:0]   raw;
    logic [lz_w-1:0]  lz;

    logic [ext_w-1:0]      norm;
    logic signed [ew+2:0]  exp_n, exp_r;
    logic                  round_up;
    logic [mw+1:0]         mant_r;
    logic [mw-1:0]         frac;

    function automatic logic [lz_w-1:0] lead_zeros(input logic [ext_w-1:0] v);
        logic [lz_w-1:0] n;
        logic            hit;
        n   = '0;
        hit = 1'b0;
        for (int i = ext_w - 1; i >= 0; i--) begin
            if (!hit) begin
                if (v[i]) hit = 1'b1;
                else n = n + 1'b1;
            end
        end
        return n;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Unpack and classify
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign sign_a = float_a[ew+mw];
    assign sign_b = float_b[ew+mw];
    assign exp_a  = float_a[mw +: ew];
    assign exp_b  = float_b[mw +: ew];
    assign man_a  = float_a[mw-1:0];
    assign man_b  = float_b[mw-1:0];

    assign zero_a = (exp_a == '0);  // Subnormals count as zero
    assign zero_b = (exp_b == '0);
    assign inf_a  = (exp_a == ew'(exp_max)) && (man_a == '0);
    assign inf_b  = (exp_b == ew'(exp_max)) && (man_b == '0);
    assign nan_a  = (exp_a == ew'(exp_max)) && (man_a != '0);
    assign nan_b  = (exp_b == ew'(exp_max)) && (man_b != '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Order by magnitude and align
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign a_big     = {exp_a, man_a} >= {exp_b, man_b};
    assign big_sign  = a_big ? sign_a : sign_b;
    assign big_exp   = a_big ? exp_a : exp_b;
    assign big_man   = a_big ? man_a : man_b;
    assign small_exp = a_big ? exp_b : exp_a;
    assign small_man = a_big ? man_b : man_a;
    assign diff      = big_exp - small_exp;

    assign big_ext   = {1'b1, big_man, 3'b000};
    assign small_ext = {1'b1, small_man, 3'b000};

    // Bits shifted past the round position collapse into sticky
    assign wide     = {small_ext, {(sh_w - ext_w){1'b0}}} >> diff;
    assign small_al = {wide[sh_w-1 -: ext_w-1],
                       wide[sh_w-ext_w] | (|wide[sh_w-ext_w-1:0])};

    assign subtract = sign_a ^ sign_b;
    assign raw = subtract ? ({1'b0, big_ext} - {1'b0, small_al})
                          : ({1'b0, big_ext} + {1'b0, small_al});
    assign lz  = lead_zeros(raw[ext_w-1:0]);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Normalize and round to nearest even
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        if (raw[ext_w]) begin
            norm  = {raw[ext_w:2], raw[1] | raw[0]};  // Carry out, keep the dropped bit as sticky
            exp_n = $signed({3'b000, big_exp}) + 8'sd1;
        end else begin
            norm  = raw[ext_w-1:0] << lz;
            exp_n = $signed({3'b000, big_exp}) - $signed({{(ew+3-lz_w){1'b0}}, lz});
        end
    end

    assign round_up = norm[2] & (norm[1] | norm[0] | norm[3]);
    assign mant_r   = {1'b0, norm[ext_w-1:3]} + {{(mw+1){1'b0}}, round_up};

    always_comb begin
        if (mant_r[mw+1]) begin
            exp_r = exp_n + 8'sd1;  // Rounding carried into a new binade
            frac  = mant_r[mw:1];
        end else begin
            exp_r = exp_n;
            frac  = mant_r[mw-1:0];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        if (nan_a || nan_b || (inf_a && inf_b && subtract)) begin
            sum = float_qnan;
        end else if (inf_a) begin
            sum = sign_a ? float_inf_neg : float_inf_pos;
        end else if (inf_b) begin
            sum = sign_b ? float_inf_neg : float_inf_pos;
        end else if (zero_a && zero_b) begin
            sum = {sign_a & sign_b, {(ew + mw){1'b0}}};
        end else if (zero_a) begin
            sum = float_b;
        end else if (zero_b) begin
            sum = float_a;
        end else if (raw == '0) begin
            sum = '0;  // Exact cancellation gives +0
        end else if (exp_r >= exp_max) begin
            sum = big_sign ? float_inf_neg : float_inf_pos;
        end else if (exp_r <= 0) begin
            sum = {big_sign, {(ew + mw){1'b0}}};  // Underflow flushes to zero
        end else begin
            sum = {big_sign, exp_r[ew-1:0], frac};
        end
    end

endmodule

/* logic/matrix_ram.sv */
`timescale 1ns/100ps

module matrix_ram #(
    parameter int addr_width = 14
) (
    input  logic                  clk,
    input  logic [addr_width-1:0] a_address,
    input  matrix_pkg::float16_t  a_writedata,
    input  logic                  a_write_en,
    output matrix_pkg::float16_t  a_readdata,
    input  logic [addr_width-1:0] b_address,
    input  matrix_pkg::float16_t  b_writedata,
    input  logic                  b_write_en,
    output matrix_pkg::float16_t  b_readdata
);
    import matrix_pkg::*;

    localparam int depth = 2 ** addr_width;

    float16_t mem [depth];

    // Port A is written last, so it wins a same-address collision
    always_ff @(posedge clk) begin
        if (b_write_en) begin
            mem[b_address] <= b_writedata;
        end
        if (a_write_en) begin
            mem[a_address] <= a_writedata;
        end
    end

    assign a_readdata = mem[a_address];  // Asynchronous reads
    assign b_readdata = mem[b_address];

endmodule

/* logic/matrix_addition.sv */
`timescale 1ns/100ps

module matrix_addition #(
    parameter int addr_width = 14,
    parameter int dim_width  = 10
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    output logic                 done,
    input  logic [dim_width-1:0] rows,
    input  logic [dim_width-1:0] cols,
    input  logic [addr_width-1:0] src1_base,
    input  logic [addr_width-1:0] src2_base,
    input  logic [addr_width-1:0] dest_base,
    output logic [addr_width-1:0] src1_address,
    output logic [addr_width-1:0] src2_address,
    input  matrix_pkg::float16_t  sum,
    output logic [addr_width-1:0] dest_address,
    output matrix_pkg::float16_t  dest_writedata,
    output logic                 dest_write_en
);
    import matrix_pkg::*;

    engine_state_t        state;
    logic [dim_width-1:0] row_count;
    logic [dim_width-1:0] col_count;
    logic                 col_last;
    logic                 row_last;

    assign col_last = (col_count == cols - 1'b1);
    assign row_last = (row_count == rows - 1'b1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= st_idle;
            done          <= 1'b1;
            dest_write_en <= 1'b0;
            row_count     <= '0;
            col_count     <= '0;
        end else begin
            case (state)
                st_idle: begin
                    dest_write_en <= 1'b0;  // Last write of a run lands here
                    if (start && done) begin
                        state <= st_prime;
                        done  <= 1'b0;
                    end else begin
                        done <= 1'b1;
                    end
                end
                st_prime: begin
                    row_count <= '0;
                    col_count <= '0;
                    state     <= st_run;
                end
                st_run: begin
                    dest_write_en <= 1'b1;
                    if (col_last) begin
                        col_count <= '0;
                        if (row_last) begin
                            state <= st_idle;
                        end else begin
                            row_count <= row_count + 1'b1;
                        end
                    end else begin
                        col_count <= col_count + 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address and data path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        case (state)
            st_prime: begin
                src1_address <= src1_base;
                src2_address <= src2_base;
                dest_address <= dest_base - 1'b1;  // First run cycle steps onto dest_base
            end
            st_run: begin
                src1_address   <= src1_address + 1'b1;
                src2_address   <= src2_address + 1'b1;
                dest_address   <= dest_address + 1'b1;
                dest_writedata <= sum;  // Sum of the words at the current source addresses
            end
            default: begin
            end
        endcase
    end

endmodule

/* logic/matrix_accel_top.sv */
`timescale 1ns/100ps

module matrix_accel_top #(
    parameter int addr_width = 14,
    parameter int dim_width  = 10
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    output logic                  done,
    input  logic [dim_width-1:0]  rows,
    input  logic [dim_width-1:0]  cols,
    input  logic [addr_width-1:0] src1_base,
    input  logic [addr_width-1:0] src2_base,
    input  logic [addr_width-1:0] dest_base,
    input  logic                  host_src_sel,
    input  logic                  host_src_write_en,
    input  logic [addr_width-1:0] host_address,
    input  matrix_pkg::float16_t  host_writedata,
    output matrix_pkg::float16_t  host_dest_readdata
);
    import matrix_pkg::*;

    logic [addr_width-1:0] src1_address;
    logic [addr_width-1:0] src2_address;
    logic [addr_width-1:0] dest_address;
    float16_t              src1_readdata;
    float16_t              src2_readdata;
    float16_t              sum;
    float16_t              dest_writedata;
    logic                  dest_write_en;
    logic                  src1_host_write_en;
    logic                  src2_host_write_en;

    assign src1_host_write_en = host_src_write_en & ~host_src_sel;
    assign src2_host_write_en = host_src_write_en & host_src_sel;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memories, engine on port A and host on port B
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    matrix_ram #(.addr_width(addr_width)) u_src1_ram (
        .clk         (clk),
        .a_address   (src1_address),
        .a_writedata ('0),
        .a_write_en  (1'b0),
        .a_readdata  (src1_readdata),
        .b_address   (host_address),
        .b_writedata (host_writedata),
        .b_write_en  (src1_host_write_en),
        .b_readdata  ()
    );

    matrix_ram #(.addr_width(addr_width)) u_src2_ram (
        .clk         (clk),
        .a_address   (src2_address),
        .a_writedata ('0),
        .a_write_en  (1'b0),
        .a_readdata  (src2_readdata),
        .b_address   (host_address),
        .b_writedata (host_writedata),
        .b_write_en  (src2_host_write_en),
        .b_readdata  ()
    );

    matrix_ram #(.addr_width(addr_width)) u_dest_ram (
        .clk         (clk),
        .a_address   (dest_address),
        .a_writedata (dest_writedata),
        .a_write_en  (dest_write_en),
        .a_readdata  (),
        .b_address   (host_address),
        .b_writedata ('0),
        .b_write_en  (1'b0),
        .b_readdata  (host_dest_readdata)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Engine and adder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    matrix_addition #(
        .addr_width (addr_width),
        .dim_width  (dim_width)
    ) u_matrix_addition (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .done           (done),
        .rows           (rows),
        .cols           (cols),
        .src1_base      (src1_base),
        .src2_base      (src2_base),
        .dest_base      (dest_base),
        .src1_address   (src1_address),
        .src2_address   (src2_address),
        .sum            (sum),
        .dest_address   (dest_address),
        .dest_writedata (dest_writedata),
        .dest_write_en  (dest_write_en)
    );

    float16_add u_float16_add (
        .float_a (src1_readdata),
        .float_b (src2_readdata),
        .sum     (sum)
    );

endmodule

/* tb/matrix_accel_assert.sv */
`timescale 1ns/100ps

module matrix_addition_assert (
    input logic                      clk,
    input logic                      reset,
    input logic                      start,
    input logic                      done,
    input logic                      dest_write_en,
    input matrix_pkg::engine_state_t state
);
    import matrix_pkg::*;

    write_while_done: assert property (@(posedge clk) disable iff (reset)
        !(dest_write_en && done))
        else $error("dest_write_en high while done is high");

    done_falls_on_start: assert property (@(posedge clk) disable iff (reset)
        $fell(done) |-> ($past(start) && $past(state) == st_idle))
        else $error("done fell without a start in st_idle");

    legal_state: assert property (@(posedge clk) disable iff (reset)
        state inside {st_idle, st_prime, st_run})
        else $error("engine state outside the enum");

    quiet_prime: assert property (@(posedge clk) disable iff (reset)
        (state == st_prime) |-> !dest_write_en)
        else $error("dest_write_en high in st_prime");

endmodule

bind matrix_addition matrix_addition_assert u_matrix_addition_assert (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .done          (done),
    .dest_write_en (dest_write_en),
    .state         (state)
);

/* tb/matrix_accel_tb.sv */
`timescale 1ns/100ps

module matrix_accel_tb;
    import matrix_pkg::*;

    localparam int addr_width = 14;
    localparam int dim_width  = 10;

    logic                  clk;
    logic                  reset;
    logic                  start;
    logic                  done;
    logic [dim_width-1:0]  rows;
    logic [dim_width-1:0]  cols;
    logic [addr_width-1:0] src1_base;
    logic [addr_width-1:0] src2_base;
    logic [addr_width-1:0] dest_base;
    logic                  host_src_sel;
    logic                  host_src_write_en;
    logic [addr_width-1:0] host_address;
    float16_t              host_writedata;
    float16_t              host_dest_readdata;

    int    cycles;
    int    limit;
    bit    limit_ready;
    string test_name;

    matrix_accel_top #(
        .addr_width (addr_width),
        .dim_width  (dim_width)
    ) u_matrix_accel_top (
        .clk                (clk),
        .reset              (reset),
        .start              (start),
        .done               (done),
        .rows               (rows),
        .cols               (cols),
        .src1_base          (src1_base),
        .src2_base          (src2_base),
        .dest_base          (dest_base),
        .host_src_sel       (host_src_sel),
        .host_src_write_en  (host_src_write_en),
        .host_address       (host_address),
        .host_writedata     (host_writedata),
        .host_dest_readdata (host_dest_readdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit_ready && cycles >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Test failures found");
            $fatal(1);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host side tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic write_source(input logic sel, input logic [addr_width-1:0] addr,
                                input float16_t word);
        @(posedge clk);
        #1;
        host_src_sel      = sel;
        host_address      = addr;
        host_writedata    = word;
        host_src_write_en = 1'b1;
        @(posedge clk);  // Word lands on this edge
        #1;
        host_src_write_en = 1'b0;
    endtask

    task automatic read_dest(input logic [addr_width-1:0] addr, output float16_t word);
        @(posedge clk);
        #1;
        host_address = addr;
        #1;
        word = host_dest_readdata;  // Asynchronous read
    endtask

    task automatic run_engine(input int elements);
        int n;
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        check_value({test_name, " done low after start"}, 32'd0, 32'(done));
        start = 1'b1;  // Second pulse while busy must be ignored
        @(posedge clk);
        #1;
        start = 1'b0;
        n = 1;
        while (!done) begin
            @(posedge clk);
            #1;
            n++;
        end
        check_value({test_name, " cycles to done"}, 32'(elements + 2), 32'(n));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int                    fd;
        string                 line;
        logic [7:0]            kind;
        logic [dim_width-1:0]  t_rows;
        logic [dim_width-1:0]  t_cols;
        logic [addr_width-1:0] b1, b2, bd, addr;
        float16_t              word;
        float16_t              got;
        string                 name;
        bit                    ran;
        int                    count;

        cycles            = 0;
        limit             = 40;  // Reset and idle checks
        limit_ready       = 1'b0;
        reset             = 1'b1;
        start             = 1'b0;
        rows              = '0;
        cols              = '0;
        src1_base         = '0;
        src2_base         = '0;
        dest_base         = '0;
        host_src_sel      = 1'b0;
        host_src_write_en = 1'b0;
        host_address      = '0;
        host_writedata    = '0;
        ran               = 1'b1;

        fd = $fopen("tb/matrix_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            $display("Test failures found");
            $fatal(1);
        end
        while ($fgets(line, fd) != 0) begin
            kind = line.getc(0);
            if (kind == "T") begin
                count = $sscanf(line, "T %s %h %h %h %h %h", name, t_rows, t_cols, b1, b2, bd);
                check_value("test data header fields", 32'd6, 32'(count));
                limit = limit + int'(t_rows) * int'(t_cols) + 20;
            end else if (kind == "A" || kind == "B" || kind == "E") begin
                limit = limit + 3;
            end
        end
        $fclose(fd);
        limit_ready = 1'b1;

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (3) begin
            check_value("reset done high", 32'd1, 32'(done));
            @(posedge clk);
            #1;
        end

        fd = $fopen("tb/matrix_testdata.txt", "r");
        while ($fgets(line, fd) != 0) begin
            kind = line.getc(0);
            if (kind == "T") begin
                count = $sscanf(line, "T %s %h %h %h %h %h", name, t_rows, t_cols, b1, b2, bd);
                check_value("test data header fields", 32'd6, 32'(count));
                @(posedge clk);
                #1;
                test_name = name;
                rows      = t_rows;
                cols      = t_cols;
                src1_base = b1;
                src2_base = b2;
                dest_base = bd;
                ran       = 1'b0;
            end else if (kind == "A" || kind == "B") begin
                count = $sscanf(line.substr(1, line.len() - 1), "%h %h", addr, word);
                check_value({test_name, " source line fields"}, 32'd2, 32'(count));
                write_source(kind == "B", addr, word);
            end else if (kind == "E") begin
                if (!ran) begin
                    run_engine(int'(rows) * int'(cols));
                    ran = 1'b1;
                end
                count = $sscanf(line.substr(1, line.len() - 1), "%h %h", addr, word);
                check_value({test_name, " expect line fields"}, 32'd2, 32'(count));
                read_dest(addr, got);
                check_value({test_name, " dest word"}, 32'(word), 32'(got));
            end
        end
        $fclose(fd);

        $display("All tests passed!");
        $finish;
    end

endmodule

/* tb/matrix_testdata.txt */
# T name rows cols src1_base src2_base dest_base, all numbers hex
# A addr word (src1), B addr word (src2), E addr expected_dest_word
T t_square 2 2 0 0 0
A 0 3C00
A 1 3E00
A 2 BC00
A 3 4100
B 0 4000
B 1 3800
B 2 4200
B 3 4400
E 0 4200
E 1 4000
E 2 4000
E 3 4680
T t_round 1 4 10 10 10
A 10 4500
A 11 3C00
A 12 3C01
A 13 7000
B 10 C500
B 11 1000
B 12 1000
B 13 3C00
E 10 0000
E 11 3C00
E 12 3C02
E 13 7000
T t_special 2 4 20 28 1A
A 20 7C00
A 21 FC00
A 22 7C00
A 23 7E01
A 24 3C00
A 25 7BFF
A 26 0200
A 27 0401
B 28 3C00
B 29 4000
B 2A FC00
B 2B 3C00
B 2C FD00
B 2D 7BFF
B 2E 0100
B 2F 8400
E 1A 7C00
E 1B FC00
E 1C 7E00
E 1D 7E00
E 1E 7E00
E 1F 7C00
E 20 0000
E 21 0000
T t_rect 2 3 40 55 14
A 40 3C00
A 41 4000
A 42 4200
A 43 4400
A 44 3800
A 45 4500
B 55 3C00
B 56 4000
B 57 3C00
B 58 C000
B 59 3800
B 5A 3C00
E 13 7000
E 14 4000
E 15 4400
E 16 4400
E 17 4000
E 18 3C00
E 19 4600
E 1A 7C00

/* src.f */
logic/matrix_pkg.sv
logic/float16_add.sv
logic/matrix_ram.sv
logic/matrix_addition.sv
logic/matrix_accel_top.sv
tb/matrix_accel_assert.sv
tb/matrix_accel_tb.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f src.f --top-module matrix_accel_tb \
		-Mdir obj_dir -o matrix_accel_sim

run: compile
	./obj_dir/matrix_accel_sim

clean:
	rm -rf obj_dir
